// File: dv/udp_demux_tb_checks.svh
/*
 * compare tasks and error counters, included inside udp_demux_tb after the imports
 * value errors print one ERR line per field
 */

// header as seen on the shared m_ fields
typedef struct packed {
    ip_addr_t  src_ip;
    ip_addr_t  dst_ip;
    udp_port_t src_port;
    udp_port_t dst_port;
    udp_len_t  length;
} hdr_t;

int err_count = 0;
int check_count = 0;

task automatic report_mismatch(input string sig, input int port, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("ERR %s port %0d got %h exp %h", sig, port, got, exp);
    err_count++;
endtask

task automatic check_hdr(input int port, input hdr_t got, input hdr_t exp);
    check_count++;
    if (got.src_ip !== exp.src_ip)
        report_mismatch("m_ip_source_ip", port, got.src_ip, exp.src_ip);
    if (got.dst_ip !== exp.dst_ip)
        report_mismatch("m_ip_dest_ip", port, got.dst_ip, exp.dst_ip);
    if (got.src_port !== exp.src_port)
        report_mismatch("m_udp_source_port", port, 32'(got.src_port), 32'(exp.src_port));
    if (got.dst_port !== exp.dst_port)
        report_mismatch("m_udp_dest_port", port, 32'(got.dst_port), 32'(exp.dst_port));
    if (got.length !== exp.length)
        report_mismatch("m_udp_length", port, 32'(got.length), 32'(exp.length));
endtask

task automatic check_beat(input int port, input payload_t got_data, input logic got_last,
                          input payload_t exp_data, input logic exp_last);
    check_count++;
    if (got_data !== exp_data)
        report_mismatch("m_payload_tdata", port, 32'(got_data), 32'(exp_data));
    if (got_last !== exp_last)
        report_mismatch("m_payload_tlast", port, 32'(got_last), 32'(exp_last));
endtask

// valid on a port that has nothing routed to it
task automatic check_port(input int port, input string sig);
    $display("%s is high on port %0d, but no frame is routed there", sig, port);
    err_count++;
endtask

task automatic ready_held_low(input string sig, input logic got);
    check_count++;
    if (got !== 1'b0)
        report_mismatch(sig, 0, 32'(got), 32'h0);
endtask

// File: dv/udp_demux_tb.sv
/*
 * testbench for udp_demux_top with four ports, frames taken from a table
 * each frame drains on its port before the next one is sent
 */
module udp_demux_tb;
    import udp_hdr_pkg::*;
    import udp_demux_pkg::*;

    `include "udp_demux_tb_checks.svh"

    localparam int PORTS = 4;
    localparam int NUM_FRAMES = 8;

    typedef struct packed {
        logic     last;
        payload_t data;
    } beat_t;

    // stall is the percent chance that a port's ready is low in a cycle
    typedef struct packed {
        logic [1:0] sel;
        logic       drp;
        ip_addr_t   src_ip;
        ip_addr_t   dst_ip;
        udp_port_t  src_port;
        udp_port_t  dst_port;
        udp_len_t   length;
        int         len;
        int         gap;
        int         stall;
    } frame_t;

    frame_t tab [NUM_FRAMES] = '{
        '{2'd0, 1'b0, 32'hc0a8_0001, 32'h0a00_0001, 16'd1024, 16'd80, 16'd13, 5, 0, 0},
        '{2'd1, 1'b0, 32'hc0a8_0102, 32'h0a00_0002, 16'd5353, 16'd53, 16'd17, 9, 3, 30},
        '{2'd2, 1'b1, 32'hac10_0203, 32'h0a00_0003, 16'd4000, 16'd69, 16'd14, 6, 2, 0},
        '{2'd3, 1'b0, 32'hac10_0304, 32'h0a00_0004, 16'd6000, 16'd123, 16'd9, 1, 0, 50},
        '{2'd2, 1'b0, 32'h0102_0304, 32'hffff_fffe, 16'hbeef, 16'h1f90, 16'd20, 12, 4, 60},
        '{2'd1, 1'b1, 32'h7f00_0001, 32'h7f00_0002, 16'd7, 16'd9, 16'd11, 3, 0, 40},
        '{2'd0, 1'b0, 32'h8000_0000, 32'h0000_0001, 16'hffff, 16'h0001, 16'd24, 16, 2, 70},
        '{2'd3, 1'b0, 32'hdead_beef, 32'hcafe_f00d, 16'h8001, 16'h0400, 16'd15, 7, 0, 20}
    };

    logic clk;
    logic rst;
    logic enable;
    logic drop;
    logic [1:0] select;
    logic s_hdr_valid;
    logic s_hdr_ready;
    ip_addr_t s_ip_source_ip;
    ip_addr_t s_ip_dest_ip;
    udp_port_t s_udp_source_port;
    udp_port_t s_udp_dest_port;
    udp_len_t s_udp_length;
    payload_t s_payload_tdata;
    logic s_payload_tvalid;
    logic s_payload_tready;
    logic s_payload_tlast;
    logic [PORTS-1:0] m_hdr_valid;
    logic [PORTS-1:0] m_hdr_ready;
    ip_addr_t m_ip_source_ip;
    ip_addr_t m_ip_dest_ip;
    udp_port_t m_udp_source_port;
    udp_port_t m_udp_dest_port;
    udp_len_t m_udp_length;
    payload_t m_payload_tdata;
    logic [PORTS-1:0] m_payload_tvalid;
    logic [PORTS-1:0] m_payload_tready;
    logic m_payload_tlast;

    hdr_t exp_hdr [PORTS][$];
    beat_t exp_beat [PORTS][$];
    int stall_pct;

    udp_demux_top #(.M_COUNT(PORTS)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int watchdog_cycles();
        int n;
        int total;
        total = 0;
        for (n = 0; n < NUM_FRAMES; n++)
            total += tab[n].len + tab[n].gap + 4;
        return total * 20 + 200;
    endfunction

    initial begin
        repeat (watchdog_cycles()) @(posedge clk);
        $display("timeout: frames did not finish within %0d cycles", watchdog_cycles());
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic queues_busy();
        int p;
        queues_busy = 1'b0;
        for (p = 0; p < PORTS; p++)
            if (exp_hdr[p].size() != 0 || exp_beat[p].size() != 0)
                queues_busy = 1'b1;
    endfunction

    task automatic send_frame(input frame_t f);
        int i;
        hdr_t h;
        beat_t eb;
        @(negedge clk);
        select            = f.sel;
        drop              = f.drp;
        s_ip_source_ip    = f.src_ip;
        s_ip_dest_ip      = f.dst_ip;
        s_udp_source_port = f.src_port;
        s_udp_dest_port   = f.dst_port;
        s_udp_length      = f.length;
        s_hdr_valid       = 1'b1;
        h = {f.src_ip, f.dst_ip, f.src_port, f.dst_port, f.length};
        if (!f.drp)
            exp_hdr[f.sel].push_back(h);
        do begin
            @(posedge clk);
        end while (!s_hdr_ready);
        @(negedge clk);
        s_hdr_valid = 1'b0;
        // routing inputs change mid frame and must not matter
        select = ~f.sel;
        drop   = ~f.drp;
        for (i = 0; i < f.len; i++) begin
            eb = {i == f.len - 1, payload_t'($urandom)};
            s_payload_tdata  = eb.data;
            s_payload_tlast  = eb.last;
            s_payload_tvalid = 1'b1;
            if (!f.drp)
                exp_beat[f.sel].push_back(eb);
            // enable gap in the middle of the frame, beat held valid
            if (i == f.len / 2 && f.gap > 0) begin
                enable = 1'b0;
                repeat (f.gap) begin
                    @(posedge clk);
                    ready_held_low("s_hdr_ready", s_hdr_ready);
                    ready_held_low("s_payload_tready", s_payload_tready);
                end
                @(negedge clk);
                enable = 1'b1;
            end
            do begin
                @(posedge clk);
            end while (!s_payload_tready);
            @(negedge clk);
        end
        s_payload_tvalid = 1'b0;
        s_payload_tlast  = 1'b0;
    endtask

    // port monitors; outputs are registered so negedge values are stable
    initial begin
        int p;
        hdr_t got_h;
        beat_t eb;
        m_hdr_ready      = '0;
        m_payload_tready = '0;
        forever begin
            @(negedge clk);
            // readies that the next rising edge will see
            for (p = 0; p < PORTS; p++) begin
                m_hdr_ready[p]      = int'($urandom_range(99)) >= stall_pct;
                m_payload_tready[p] = int'($urandom_range(99)) >= stall_pct;
            end
            for (p = 0; p < PORTS && !rst; p++) begin
                if (m_hdr_valid[p] && exp_hdr[p].size() == 0) begin
                    check_port(p, "m_hdr_valid");
                end else if (m_hdr_valid[p] && m_hdr_ready[p]) begin
                    got_h = {m_ip_source_ip, m_ip_dest_ip, m_udp_source_port,
                             m_udp_dest_port, m_udp_length};
                    check_hdr(p, got_h, exp_hdr[p].pop_front());
                end
                if (m_payload_tvalid[p] && exp_beat[p].size() == 0) begin
                    check_port(p, "m_payload_tvalid");
                end else if (m_payload_tvalid[p] && m_payload_tready[p]) begin
                    eb = exp_beat[p].pop_front();
                    check_beat(p, m_payload_tdata, m_payload_tlast, eb.data, eb.last);
                end
            end
        end
    end

    initial begin
        int n;
        int errs_before;
        void'($urandom(37869));
        rst               = 1'b1;
        enable            = 1'b1;
        drop              = 1'b0;
        select            = '0;
        s_hdr_valid       = 1'b0;
        s_ip_source_ip    = '0;
        s_ip_dest_ip      = '0;
        s_udp_source_port = '0;
        s_udp_dest_port   = '0;
        s_udp_length      = '0;
        s_payload_tdata   = '0;
        s_payload_tvalid  = 1'b0;
        s_payload_tlast   = 1'b0;
        stall_pct         = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (n = 0; n < NUM_FRAMES; n++) begin
            errs_before = err_count;
            stall_pct   = tab[n].stall;
            send_frame(tab[n]);
            while (queues_busy())
                @(posedge clk);
            if (tab[n].drp)
                $display("frame %0d: dropped, %0d bytes, %0d errors",
                         n, tab[n].len, err_count - errs_before);
            else
                $display("frame %0d: port %0d, %0d bytes, %0d errors",
                         n, tab[n].sel, tab[n].len, err_count - errs_before);
        end
        $display("done: %0d frames, %0d checks, %0d errors", NUM_FRAMES, check_count, err_count);
        if (err_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: flist.f
+incdir+dv
hdl/udp_hdr_pkg.sv
hdl/udp_demux_pkg.sv
hdl/udp_demux_ctrl.sv
hdl/udp_payload_skid.sv
hdl/udp_demux_top.sv
dv/udp_demux_tb.sv

// File: hdl/udp_demux_ctrl.sv
/*
 * frame control for the UDP demux; select and drop count only at header accept
 * M_COUNT must be 2 or more; header fields are shared by all ports
 */
module udp_demux_ctrl #(
    parameter int M_COUNT = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enable,
    input  logic                        drop,
    input  logic [$clog2(M_COUNT)-1:0]  select,

    input  logic                        s_hdr_valid,
    output logic                        s_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t       s_ip_source_ip,
    input  udp_hdr_pkg::ip_addr_t       s_ip_dest_ip,
    input  udp_hdr_pkg::udp_port_t      s_udp_source_port,
    input  udp_hdr_pkg::udp_port_t      s_udp_dest_port,
    input  udp_hdr_pkg::udp_len_t       s_udp_length,

    output logic [M_COUNT-1:0]          m_hdr_valid,
    input  logic [M_COUNT-1:0]          m_hdr_ready,
    output udp_hdr_pkg::ip_addr_t       m_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t       m_ip_dest_ip,
    output udp_hdr_pkg::udp_port_t      m_udp_source_port,
    output udp_hdr_pkg::udp_port_t      m_udp_dest_port,
    output udp_hdr_pkg::udp_len_t       m_udp_length,

    input  udp_demux_pkg::payload_t     s_payload_tdata,
    input  logic                        s_payload_tvalid,
    output logic                        s_payload_tready,
    input  logic                        s_payload_tlast,

    input  logic                        out_ready_early,
    output udp_demux_pkg::payload_t     beat_data,
    output logic                        beat_last,
    output logic [M_COUNT-1:0]          beat_valid
);
    import udp_demux_pkg::*;

    localparam int SEL_W = $clog2(M_COUNT);

    frame_state_e       state_q;
    frame_state_e       state_d;
    logic [SEL_W-1:0]   sel_q;
    logic [SEL_W-1:0]   sel_d;
    logic [M_COUNT-1:0] hdr_valid_d;
    logic               hdr_ready_q;
    logic               early_q;
    logic               hdr_xfer;
    logic               pay_xfer;

    assign s_hdr_ready = hdr_ready_q && enable;

    // payload side follows the output stage, except while discarding
    assign s_payload_tready = (early_q || state_q == FRAME_DROP) &&
                              state_q != FRAME_IDLE && enable;

    assign hdr_xfer = state_q == FRAME_IDLE && s_hdr_valid && s_hdr_ready;
    assign pay_xfer = s_payload_tvalid && s_payload_tready;

    always_comb begin
        state_d     = state_q;
        sel_d       = sel_q;
        hdr_valid_d = m_hdr_valid & ~m_hdr_ready;

        // end of frame
        if (pay_xfer && s_payload_tlast) begin
            state_d = FRAME_IDLE;
        end

        // start of frame, latch routing
        if (hdr_xfer) begin
            sel_d       = select;
            state_d     = drop ? FRAME_DROP : FRAME_PASS;
            hdr_valid_d = drop ? '0 : M_COUNT'(1) << select;
        end
    end

    // beats go on unregistered; the payload stage holds them
    assign beat_data  = s_payload_tdata;
    assign beat_last  = s_payload_tlast;
    assign beat_valid = (pay_xfer && state_q == FRAME_PASS) ? M_COUNT'(1) << sel_q : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= FRAME_IDLE;
            sel_q       <= '0;
            m_hdr_valid <= '0;
            hdr_ready_q <= 1'b0;
            early_q     <= 1'b0;
        end else begin
            state_q     <= state_d;
            sel_q       <= sel_d;
            m_hdr_valid <= hdr_valid_d;
            // next header only once frame is done and header taken
            hdr_ready_q <= state_d == FRAME_IDLE && hdr_valid_d == '0;
            early_q     <= out_ready_early;
        end
    end

    // header register
    always_ff @(posedge clk) begin
        if (hdr_xfer) begin
            m_ip_source_ip    <= s_ip_source_ip;
            m_ip_dest_ip      <= s_ip_dest_ip;
            m_udp_source_port <= s_udp_source_port;
            m_udp_dest_port   <= s_udp_dest_port;
            m_udp_length      <= s_udp_length;
        end
    end

endmodule

// File: hdl/udp_demux_pkg.sv
/*
 * demux defaults, payload beat type and frame state encoding
 * payload is byte wide, no tkeep/tuser sideband
 */
package udp_demux_pkg;

    // default number of output ports
    localparam int DEFAULT_M_COUNT = 4;

    // payload beat width
    localparam int PAYLOAD_WIDTH = 8;

    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

    // frame control states
    typedef enum logic [1:0] {
        FRAME_IDLE = 2'd0,
        FRAME_PASS = 2'd1,
        FRAME_DROP = 2'd2
    } frame_state_e;

endpackage

// File: hdl/udp_demux_top.sv
/*
 * UDP frame demux, one input stream to M_COUNT ports selected per frame
 * header fields, tdata and tlast are shared; valid/ready are per port
 */
module udp_demux_top #(
    parameter int M_COUNT = udp_demux_pkg::DEFAULT_M_COUNT
) (
    input  logic                        clk,
    input  logic                        rst,

    // input frame
    input  logic                        s_hdr_valid,
    output logic                        s_hdr_ready,
    input  udp_hdr_pkg::ip_addr_t       s_ip_source_ip,
    input  udp_hdr_pkg::ip_addr_t       s_ip_dest_ip,
    input  udp_hdr_pkg::udp_port_t      s_udp_source_port,
    input  udp_hdr_pkg::udp_port_t      s_udp_dest_port,
    input  udp_hdr_pkg::udp_len_t       s_udp_length,
    input  udp_demux_pkg::payload_t     s_payload_tdata,
    input  logic                        s_payload_tvalid,
    output logic                        s_payload_tready,
    input  logic                        s_payload_tlast,

    // output frames
    output logic [M_COUNT-1:0]          m_hdr_valid,
    input  logic [M_COUNT-1:0]          m_hdr_ready,
    output udp_hdr_pkg::ip_addr_t       m_ip_source_ip,
    output udp_hdr_pkg::ip_addr_t       m_ip_dest_ip,
    output udp_hdr_pkg::udp_port_t      m_udp_source_port,
    output udp_hdr_pkg::udp_port_t      m_udp_dest_port,
    output udp_hdr_pkg::udp_len_t       m_udp_length,
    output udp_demux_pkg::payload_t     m_payload_tdata,
    output logic [M_COUNT-1:0]          m_payload_tvalid,
    input  logic [M_COUNT-1:0]          m_payload_tready,
    output logic                        m_payload_tlast,

    // routing control
    input  logic                        enable,
    input  logic                        drop,
    input  logic [$clog2(M_COUNT)-1:0]  select
);
    import udp_demux_pkg::*;

    payload_t           beat_data;
    logic               beat_last;
    logic [M_COUNT-1:0] beat_valid;
    logic               out_ready_early;

    udp_demux_ctrl #(
        .M_COUNT(M_COUNT)
    ) ctrl_i (
        .clk               (clk),
        .rst               (rst),
        .enable            (enable),
        .drop              (drop),
        .select            (select),
        .s_hdr_valid       (s_hdr_valid),
        .s_hdr_ready       (s_hdr_ready),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .s_udp_source_port (s_udp_source_port),
        .s_udp_dest_port   (s_udp_dest_port),
        .s_udp_length      (s_udp_length),
        .m_hdr_valid       (m_hdr_valid),
        .m_hdr_ready       (m_hdr_ready),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length),
        .s_payload_tdata   (s_payload_tdata),
        .s_payload_tvalid  (s_payload_tvalid),
        .s_payload_tready  (s_payload_tready),
        .s_payload_tlast   (s_payload_tlast),
        .out_ready_early   (out_ready_early),
        .beat_data         (beat_data),
        .beat_last         (beat_last),
        .beat_valid        (beat_valid)
    );

    udp_payload_skid #(
        .M_COUNT(M_COUNT)
    ) skid_i (
        .clk              (clk),
        .rst              (rst),
        .beat_data        (beat_data),
        .beat_last        (beat_last),
        .beat_valid       (beat_valid),
        .out_ready_early  (out_ready_early),
        .m_payload_tdata  (m_payload_tdata),
        .m_payload_tlast  (m_payload_tlast),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tready (m_payload_tready)
    );

endmodule

// File: hdl/udp_hdr_pkg.sv
/*
 * reduced UDP/IP header field types, shared by RTL and testbench
 * only addresses, ports and length are carried; no checksum
 */
package udp_hdr_pkg;

    // IPv4 address, network order as received
    typedef logic [31:0] ip_addr_t;

    // UDP source or destination port
    typedef logic [15:0] udp_port_t;

    // UDP length field, header plus payload bytes
    typedef logic [15:0] udp_len_t;

endpackage

// File: hdl/udp_payload_skid.sv
/*
 * payload output register with one temporary register behind it
 * holds at most two beats; input ready is registered from out_ready_early
 */
module udp_payload_skid #(
    parameter int M_COUNT = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_demux_pkg::payload_t  beat_data,
    input  logic                     beat_last,
    input  logic [M_COUNT-1:0]       beat_valid,
    output logic                     out_ready_early,
    output udp_demux_pkg::payload_t  m_payload_tdata,
    output logic                     m_payload_tlast,
    output logic [M_COUNT-1:0]       m_payload_tvalid,
    input  logic [M_COUNT-1:0]       m_payload_tready
);
    import udp_demux_pkg::*;

    payload_t           tmp_data;
    logic               tmp_last;
    logic [M_COUNT-1:0] tmp_valid_q;
    logic [M_COUNT-1:0] tmp_valid_d;
    logic [M_COUNT-1:0] out_valid_d;
    logic               in_ready_q;
    logic               out_drain;
    logic               load_out_in;
    logic               load_out_tmp;
    logic               load_tmp;

    // output register handed off on its own port this cycle
    assign out_drain = |(m_payload_tready & m_payload_tvalid);

    // room next cycle if draining now or both registers empty
    assign out_ready_early = out_drain || (tmp_valid_q == '0 && m_payload_tvalid == '0);

    always_comb begin
        out_valid_d  = m_payload_tvalid;
        tmp_valid_d  = tmp_valid_q;
        load_out_in  = 1'b0;
        load_out_tmp = 1'b0;
        load_tmp     = 1'b0;

        if (in_ready_q) begin
            if (out_drain || m_payload_tvalid == '0) begin
                // straight to output
                out_valid_d = beat_valid;
                load_out_in = 1'b1;
            end else begin
                // output stalled, park in temp
                tmp_valid_d = beat_valid;
                load_tmp    = 1'b1;
            end
        end else if (out_drain) begin
            // input blocked, refill output from temp
            out_valid_d  = tmp_valid_q;
            tmp_valid_d  = '0;
            load_out_tmp = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_tvalid <= '0;
            tmp_valid_q      <= '0;
            in_ready_q       <= 1'b0;
        end else begin
            m_payload_tvalid <= out_valid_d;
            tmp_valid_q      <= tmp_valid_d;
            in_ready_q       <= out_ready_early;
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (load_out_in) begin
            m_payload_tdata <= beat_data;
            m_payload_tlast <= beat_last;
        end else if (load_out_tmp) begin
            m_payload_tdata <= tmp_data;
            m_payload_tlast <= tmp_last;
        end

        if (load_tmp) begin
            tmp_data <= beat_data;
            tmp_last <= beat_last;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the UDP demux testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module udp_demux_tb -o udp_demux_sim
./obj_dir/udp_demux_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx '>>> PASS' sim.log; then
    exit 0
fi
exit 1
